//--- Multiplier.sv
`timescale 1ns/1ns

module Multiplier
(
    input  logic         Clk,
    input  logic         rstN,
    input  mulPkg::byteT s,
    input  logic         run,
    input  logic         clearALoadB,
    output mulPkg::byteT aVal,
    output mulPkg::byteT bVal,
    output logic         x,
    output mulPkg::segT  aHexU,
    output mulPkg::segT  aHexL,
    output mulPkg::segT  bHexU,
    output mulPkg::segT  bHexL
);
    import mulPkg::*;

    logic runSync;
    logic clearSync;
    logic clrLd;
    logic latchOp;
    logic subOp;
    logic loadA;
    logic shiftEn;
    logic aOut;
    logic bOut;
    logic opSub;
    logic newRun;
    logic signOut;
    byteT opA;
    byteT opB;
    byteT sum;
    segT  aHexUComb;
    segT  aHexLComb;
    segT  bHexUComb;
    segT  bHexLComb;

    // ########################################################################
    // buttons and control
    // ########################################################################

    buttonSync runSyncInst   (.Clk(Clk), .rstN(rstN), .async(run), .sync(runSync));
    buttonSync clearSyncInst (.Clk(Clk), .rstN(rstN), .async(clearALoadB), .sync(clearSync));

    controlUnit ctrl
    (
        .Clk(Clk), .rstN(rstN), .runSync(runSync), .clearSync(clearSync), .m(bOut),
        .clrLd(clrLd), .latchOp(latchOp), .subOp(subOp), .loadA(loadA), .shift(shiftEn)
    );

    // ########################################################################
    // datapath
    // ########################################################################

    always_ff @(posedge Clk)
    begin
        if (latchOp)
        begin
            opA <= newRun ? '0 : aVal;
            opB <= s;                   // multiplicand straight from switches
        end
    end

    always_ff @(posedge Clk)
    begin
        if (!rstN)
        begin
            opSub <= 1'b0;
        end
        else if (latchOp)
        begin
            opSub <= subOp;
        end
    end

    assign newRun = latchOp && opSub;   // first step after a finished run

    addSub9 adder (.a(opA), .b(opB), .sub(opSub), .sum(sum), .signOut(signOut));

    always_ff @(posedge Clk)
    begin
        if (!rstN || clrLd || newRun)
        begin
            x <= 1'b0;
        end
        else if (loadA)
        begin
            x <= signOut;
        end
    end

    shiftRegister regA
    (
        .Clk(Clk), .rstN(rstN), .clear(clrLd || newRun), .load(loadA), .shift(shiftEn),
        .din(sum), .shiftIn(x), .dout(aVal), .shiftOut(aOut)
    );

    shiftRegister regB
    (
        .Clk(Clk), .rstN(rstN), .clear(1'b0), .load(clrLd), .shift(shiftEn),
        .din(s), .shiftIn(aOut), .dout(bVal), .shiftOut(bOut)
    );

    // ########################################################################
    // displays
    // ########################################################################

    hexDriver aHexUInst (.nibble(aVal[7:4]), .seg(aHexUComb));
    hexDriver aHexLInst (.nibble(aVal[3:0]), .seg(aHexLComb));
    hexDriver bHexUInst (.nibble(bVal[7:4]), .seg(bHexUComb));
    hexDriver bHexLInst (.nibble(bVal[3:0]), .seg(bHexLComb));

    always_ff @(posedge Clk)
    begin
        aHexU <= aHexUComb;             // one cycle behind aVal
        aHexL <= aHexLComb;
        bHexU <= bHexUComb;
        bHexL <= bHexLComb;
    end

endmodule

//--- addSub9.sv
`timescale 1ns/1ns

module addSub9
(
    input  mulPkg::byteT a,
    input  mulPkg::byteT b,
    input  logic         sub,
    output mulPkg::byteT sum,
    output logic         signOut
);
    logic [8:0] aExt;
    logic [8:0] bExt;
    logic [8:0] bOp;
    logic [8:0] total;

    always_comb
    begin
        aExt  = {a[7], a};
        bExt  = {b[7], b};
        bOp   = sub ? (~bExt + 9'd1) : bExt;    // negate for last step
        total = aExt + bOp;
    end

    assign sum     = total[7:0];
    assign signOut = total[8];

endmodule

//--- buttonSync.sv
`timescale 1ns/1ns

module buttonSync
(
    input  logic Clk,
    input  logic rstN,
    input  logic async,
    output logic sync
);
    logic meta;                         // first stage, may go metastable

    always_ff @(posedge Clk)
    begin
        if (!rstN)
        begin
            meta <= 1'b0;
            sync <= 1'b0;
        end
        else
        begin
            meta <= async;
            sync <= meta;
        end
    end

endmodule

//--- controlUnit.sv
`timescale 1ns/1ns

module controlUnit
(
    input  logic Clk,
    input  logic rstN,
    input  logic runSync,
    input  logic clearSync,
    input  logic m,
    output logic clrLd,
    output logic latchOp,
    output logic subOp,
    output logic loadA,
    output logic shift
);
    import mulPkg::*;

    ctrlStateT                    state;
    ctrlStateT                    stateNext;
    logic [$clog2(numSteps)-1:0]  stepCnt;      // current multiplier bit
    logic                         lastStep;

    assign lastStep = (stepCnt == $bits(stepCnt)'(numSteps - 1));

    // ########################################################################
    // state and step counter
    // ########################################################################

    always_ff @(posedge Clk)
    begin
        if (!rstN)
        begin
            state   <= idle;
            stepCnt <= '0;
        end
        else
        begin
            state <= stateNext;
            if (state == idle)
            begin
                stepCnt <= '0;
            end
            else if (state == mulPkg::shift)
            begin
                stepCnt <= stepCnt + 1'b1;
            end
        end
    end

    always_comb
    begin
        stateNext = state;
        case (state)
            idle:
            begin
                if (clearSync)
                begin
                    stateNext = clearLoad;      // clear wins over run
                end
                else if (runSync)
                begin
                    stateNext = operand;
                end
            end
            clearLoad:
            begin
                stateNext = hold;               // wait for release
            end
            operand:
            begin
                stateNext = accumulate;
            end
            accumulate:
            begin
                stateNext = mulPkg::shift;
            end
            mulPkg::shift:
            begin
                stateNext = lastStep ? hold : operand;
            end
            hold:
            begin
                if (!runSync && !clearSync)
                begin
                    stateNext = idle;
                end
            end
            default:
            begin
                stateNext = idle;
            end
        endcase
    end

    // ########################################################################
    // strobes
    // ########################################################################

    assign clrLd   = (state == clearLoad);
    assign latchOp = (state == operand);
    assign subOp   = (state == operand) && lastStep;    // sign bit of multiplier
    assign loadA   = (state == accumulate) && m;
    assign shift   = (state == mulPkg::shift);

endmodule

//--- files.f
mulPkg.sv
buttonSync.sv
controlUnit.sv
shiftRegister.sv
addSub9.sv
hexDriver.sv
Multiplier.sv
multiplier_asserts.sv
tbMultiplier.sv

//--- hexDriver.sv
`timescale 1ns/1ns

module hexDriver
(
    input  mulPkg::nibbleT nibble,
    output mulPkg::segT    seg
);

    always_comb
    begin
        case (nibble)
            4'h0: seg = 7'h40;
            4'h1: seg = 7'h79;
            4'h2: seg = 7'h24;
            4'h3: seg = 7'h30;
            4'h4: seg = 7'h19;
            4'h5: seg = 7'h12;
            4'h6: seg = 7'h02;
            4'h7: seg = 7'h78;
            4'h8: seg = 7'h00;
            4'h9: seg = 7'h10;
            4'hA: seg = 7'h08;
            4'hB: seg = 7'h03;
            4'hC: seg = 7'h46;
            4'hD: seg = 7'h21;
            4'hE: seg = 7'h06;
            4'hF: seg = 7'h0E;
            default: seg = 7'h7F;       // blank
        endcase
    end

endmodule

//--- mulPkg.sv
package mulPkg;

    // ########################################################################
    // widths
    // ########################################################################

    typedef logic [7:0] byteT;          // operand or product half
    typedef logic [3:0] nibbleT;        // one hex digit
    typedef logic [6:0] segT;           // active low, bit 0 is segment a

    // ########################################################################
    // control
    // ########################################################################

    localparam int numSteps = 8;        // multiplier bits

    typedef enum logic [2:0]
    {
        idle,
        clearLoad,
        operand,
        accumulate,
        shift,
        hold
    } ctrlStateT;

endpackage

//--- multiplier_asserts.sv
`timescale 1ns/1ns

module multiplierAsserts
(
    input logic              Clk,
    input logic              rstN,
    input mulPkg::ctrlStateT state,
    input logic              clrLd,
    input logic              latchOp,
    input logic              subOp,
    input logic              loadA,
    input logic              shiftEn
);
    import mulPkg::*;

    int assertFails = 0;                // read by the testbench at the end

    strobesExclusive: assert property (@(posedge Clk) disable iff (!rstN)
        $onehot0({clrLd, latchOp, loadA, shiftEn}))
        else
        begin
            assertFails++;
            $error("more than one control strobe high");
        end

    clrLdSingle: assert property (@(posedge Clk) disable iff (!rstN)
        clrLd |=> !clrLd)
        else
        begin
            assertFails++;
            $error("clrLd high for more than one cycle");
        end

    subOnlyWithLatch: assert property (@(posedge Clk) disable iff (!rstN)
        subOp |-> latchOp)
        else
        begin
            assertFails++;
            $error("subOp high without latchOp");
        end

    quietAfterReset: assert property (@(posedge Clk)
        !rstN |=> (state == idle) && !(clrLd || latchOp || subOp || loadA || shiftEn))
        else
        begin
            assertFails++;
            $error("control not idle and quiet after reset");
        end

endmodule

bind controlUnit multiplierAsserts chk
(
    .Clk(Clk), .rstN(rstN), .state(state), .clrLd(clrLd), .latchOp(latchOp),
    .subOp(subOp), .loadA(loadA), .shiftEn(shift)
);

//--- shiftRegister.sv
`timescale 1ns/1ns

module shiftRegister
(
    input  logic         Clk,
    input  logic         rstN,
    input  logic         clear,
    input  logic         load,
    input  logic         shift,
    input  mulPkg::byteT din,
    input  logic         shiftIn,
    output mulPkg::byteT dout,
    output logic         shiftOut
);

    always_ff @(posedge Clk)
    begin
        if (!rstN)
        begin
            dout <= '0;
        end
        else if (clear)
        begin
            dout <= '0;
        end
        else if (load)
        begin
            dout <= din;
        end
        else if (shift)
        begin
            dout <= {shiftIn, dout[7:1]};       // msb takes serial in
        end
    end

    assign shiftOut = dout[0];

endmodule

//--- tbMultiplier.sv
`timescale 1ns/1ns

module tbMultiplier;
    import mulPkg::*;

    localparam int numDirected = 25;
    localparam int numRandom   = 200;
    localparam int numOps      = 1 + 2 * numDirected + 2 * numRandom + 7;
    localparam int cycleLimit  = 40 * numOps + 100;
    localparam int runLatency  = 2 + 1 + 3 * numSteps + 1;    // sync, start, steps, display

    logic  Clk;
    logic  rstN;
    byteT  s;
    logic  run;
    logic  clearALoadB;
    byteT  aVal;
    byteT  bVal;
    logic  x;
    segT   aHexU;
    segT   aHexL;
    segT   bHexU;
    segT   bHexL;

    string testName;
    byteT  expA;
    byteT  expB;
    logic  expX;
    byteT  curB;                        // B as it should stand in the DUT
    int    errors = 0;
    int    checks = 0;
    int    cycleCount = 0;
    event  checkEv;

    Multiplier i_Multiplier
    (
        .Clk(Clk), .rstN(rstN), .s(s), .run(run), .clearALoadB(clearALoadB),
        .aVal(aVal), .bVal(bVal), .x(x),
        .aHexU(aHexU), .aHexL(aHexL), .bHexU(bHexU), .bHexL(bHexL)
    );

    initial
    begin
        Clk = 1'b0;
        forever #50 Clk = ~Clk;
    end

    // ########################################################################
    // reference model
    // ########################################################################

    function automatic logic [15:0] refProduct(byteT b, byteT m);
        int p;
        p = $signed(b) * $signed(m);
        return p[15:0];
    endfunction

    function automatic segT segRef(nibbleT n);
        case (n)
            4'h0: return 7'h40;
            4'h1: return 7'h79;
            4'h2: return 7'h24;
            4'h3: return 7'h30;
            4'h4: return 7'h19;
            4'h5: return 7'h12;
            4'h6: return 7'h02;
            4'h7: return 7'h78;
            4'h8: return 7'h00;
            4'h9: return 7'h10;
            4'hA: return 7'h08;
            4'hB: return 7'h03;
            4'hC: return 7'h46;
            4'hD: return 7'h21;
            4'hE: return 7'h06;
            default: return 7'h0E;
        endcase
    endfunction

    // ########################################################################
    // compare
    // ########################################################################

    task automatic compareField(string field, logic [15:0] expV, logic [15:0] actV);
        if (actV !== expV)
        begin
            errors++;
            $display("** Error [%s] %s: expected %h, actual %h", testName, field, expV, actV);
        end
    endtask

    always
    begin
        @(checkEv);
        checks++;
        compareField("aVal", 16'(expA), 16'(aVal));
        compareField("bVal", 16'(expB), 16'(bVal));
        compareField("x", 16'(expX), 16'(x));
        compareField("aHexU", 16'(segRef(expA[7:4])), 16'(aHexU));
        compareField("aHexL", 16'(segRef(expA[3:0])), 16'(aHexL));
        compareField("bHexU", 16'(segRef(expB[7:4])), 16'(bHexU));
        compareField("bHexL", 16'(segRef(expB[3:0])), 16'(bHexL));
    end

    always @(posedge Clk)
    begin
        cycleCount++;
        if (cycleCount >= cycleLimit)
        begin
            $display("timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // ########################################################################
    // stimulus
    // ########################################################################

    task automatic checkOutputs(string name, byteT ea, byteT eb, logic ex);
        testName = name;
        expA     = ea;
        expB     = eb;
        expX     = ex;
        -> checkEv;
    endtask

    task automatic loadB(byteT b0);
        s           = b0;
        clearALoadB = 1'b1;
        repeat (5) @(negedge Clk);      // sync, clrLd, load, display
        checkOutputs("load", 8'h00, b0, 1'b0);
        clearALoadB = 1'b0;
        repeat (4) @(negedge Clk);      // hold releases to idle
        curB = b0;
    endtask

    task automatic multiply(string name, byteT mcand, int waitCycles, bit toggleClear);
        logic [15:0] prod;
        prod = refProduct(curB, mcand);
        s    = mcand;
        run  = 1'b1;
        if (toggleClear)
        begin
            repeat (6) @(negedge Clk);
            clearALoadB = 1'b1;
            repeat (3) @(negedge Clk);
            clearALoadB = 1'b0;
            repeat (2) @(negedge Clk);
            clearALoadB = 1'b1;
            repeat (2) @(negedge Clk);
            clearALoadB = 1'b0;
            repeat (waitCycles - 13) @(negedge Clk);
        end
        else
        begin
            repeat (waitCycles) @(negedge Clk);
        end
        checkOutputs(name, prod[15:8], prod[7:0], prod[15]);
        run = 1'b0;
        repeat (4) @(negedge Clk);
        curB = prod[7:0];
    endtask

    initial
    begin
        byteT corners [5];
        byteT b0;
        byteT mc;
        int   totalErrors;

        corners     = '{8'h00, 8'h01, 8'hFF, 8'h7F, 8'h80};
        void'($urandom(32'h13c));
        rstN        = 1'b0;
        run         = 1'b0;
        clearALoadB = 1'b0;
        s           = 8'h00;
        curB        = 8'h00;
        repeat (2) @(posedge Clk);
        @(negedge Clk);
        rstN = 1'b1;
        checkOutputs("reset", 8'h00, 8'h00, 1'b0);
        @(negedge Clk);

        for (int i = 0; i < 5; i++)
        begin
            for (int j = 0; j < 5; j++)
            begin
                loadB(corners[i]);
                multiply("directed", corners[j], runLatency, 1'b0);
            end
        end

        for (int k = 0; k < numRandom; k++)
        begin
            b0 = 8'($urandom());
            mc = 8'($urandom());
            loadB(b0);
            multiply("random", mc, runLatency, 1'b0);
        end

        loadB(8'($urandom()));
        multiply("runHeld", 8'($urandom()), 60, 1'b0);          // one multiply only
        multiply("rerun", 8'($urandom()), runLatency, 1'b0);    // new B is low byte

        loadB(8'($urandom()));
        multiply("clearToggle", 8'($urandom()), runLatency, 1'b1);

        @(negedge Clk);
        totalErrors = errors + i_Multiplier.ctrl.chk.assertFails;
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, i_Multiplier.ctrl.chk.assertFails);
        if (totalErrors == 0)
        begin
            $display("SIMULATION PASSED");
        end
        else
        begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
